/* fas.f */
+incdir+.
fas_pkg.sv
fir_tap_line.sv
fir_mac.sv
frame_collector.sv
fas_top.sv
fas_checker.sv
fas_tb.sv

/* fas_checker.sv */
`timescale 1ns/1ps
`include "fas_defs.svh"

module fas_checker (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid, // Same nets that drive the DUT sample port
  input  fas_pkg::sample_t data,
  input  logic             fir_valid,
  input  fas_pkg::sample_t fir_d,
  input  logic             frame_valid,
  input  fas_pkg::sample_t frame_d [`FAS_FRAME_LEN],
  input  logic             check_totals, // Compare strobe counts with the stimulus table
  input  int               exp_fir_total,
  input  int               exp_frame_total,
  output int               errors,
  output int               pending, // Results or frames the DUT still owes
  output int               fir_seen,
  output int               frame_seen
);

  localparam int idx_w = $clog2(`FAS_FRAME_LEN);

  fas_pkg::sample_t hist [`FAS_TAPS]; // Own sample history, newest at index 0
  fas_pkg::sample_t frame_buf [`FAS_FRAME_LEN]; // Expected words of the frame in progress
  fas_pkg::sample_t exp_frame [`FAS_FRAME_LEN]; // Frame that frame_valid must deliver
  fas_pkg::sample_t exp_q [$]; // Expected filter outputs in arrival order
  int               due_q [$]; // Cycle in which each expected output must show up
  fas_pkg::sample_t exp_word;
  logic [idx_w-1:0] word_cnt; // Slot for the next expected result
  int               run_len; // Samples accepted in the current run, saturates at 32
  int               frame_due; // Zero while no frame is owed
  int               cycle_no;

  // Weighted sum of the last 32 samples, then floor division by 2^15
  function automatic fas_pkg::sample_t filter_rule();
    longint sum;
    sum = '0;
    for (int i = 0; i < `FAS_TAPS; i++) begin
      sum += longint'(fas_pkg::fir_coef[i]) * longint'(hist[i]);
    end
    return fas_pkg::sample_t'(sum >>> `FAS_COEF_FRAC);
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      exp_q.delete();
      due_q.delete();
      for (int i = 0; i < `FAS_TAPS; i++) begin
        hist[i] = '0;
      end
      word_cnt = '0;
      run_len = 0;
      frame_due = 0;
      cycle_no = 0;
      errors = 0;
      pending = 0;
      fir_seen = 0;
      frame_seen = 0;
    end else begin
      if (frame_valid) begin
        frame_seen++;
        if (frame_due != cycle_no) begin
          $display("Error: frame_valid pulsed at cycle %0d with no frame due", cycle_no);
          errors++;
        end else begin
          for (int i = 0; i < `FAS_FRAME_LEN; i++) begin
            if (frame_d[i] !== exp_frame[i]) begin
              $display("Mismatch frame_d[%0d] expected %h actual %h", i, exp_frame[i],
                       frame_d[i]);
              errors++;
            end
          end
          frame_due = 0;
        end
      end else if (frame_due != 0 && frame_due <= cycle_no) begin
        $display("Error: frame_valid never came for the frame due at cycle %0d", frame_due);
        errors++;
        frame_due = 0;
      end
      if (due_q.size() > 0 && due_q[0] == cycle_no) begin
        exp_word = exp_q.pop_front();
        void'(due_q.pop_front());
        if (!fir_valid) begin
          $display("Error: fir_valid missing at cycle %0d", cycle_no);
          errors++;
        end else begin
          fir_seen++;
          if (fir_d !== exp_word) begin
            $display("Mismatch fir_d expected %h actual %h", exp_word, fir_d);
            errors++;
          end
        end
        frame_buf[word_cnt] = exp_word; // Frames follow the expected stream
        if (word_cnt == idx_w'(`FAS_FRAME_LEN - 1)) begin
          exp_frame = frame_buf;
          frame_due = cycle_no + 1; // Collector strobes one cycle after the last word
          word_cnt = '0;
        end else begin
          word_cnt = word_cnt + idx_w'(1);
        end
      end else begin
        word_cnt = '0; // No result this cycle drops the partial frame
        if (fir_valid) begin
          fir_seen++;
          $display("Error: fir_valid pulsed at cycle %0d with no result due", cycle_no);
          errors++;
        end
      end
      if (data_valid) begin
        for (int i = `FAS_TAPS - 1; i > 0; i--) begin
          hist[i] = hist[i-1];
        end
        hist[0] = data;
        if (run_len < `FAS_TAPS) run_len++;
        if (run_len == `FAS_TAPS) begin
          exp_q.push_back(filter_rule());
          due_q.push_back(cycle_no + 2); // Tap register plus output register
        end
      end else begin
        run_len = 0; // Warm-up starts over after a gap
      end
      if (check_totals) begin
        if (fir_seen != exp_fir_total) begin
          $display("Mismatch fir_valid count expected %h actual %h", exp_fir_total, fir_seen);
          errors++;
        end
        if (frame_seen != exp_frame_total) begin
          $display("Mismatch frame_valid count expected %h actual %h", exp_frame_total,
                   frame_seen);
          errors++;
        end
      end
      pending = exp_q.size() + ((frame_due != 0) ? 1 : 0);
      cycle_no++;
    end
  end

endmodule

/* fas_defs.svh */
`ifndef FAS_DEFS_SVH
`define FAS_DEFS_SVH

// Filter geometry
`define FAS_TAPS 32 // Number of FIR taps, one coefficient per tap
`define FAS_FRAME_LEN 16 // Filter outputs gathered into one parallel frame

// Word widths
`define FAS_SAMPLE_W 16 // Signed input sample and filter output width
`define FAS_COEF_W 16 // Signed Q1.15 coefficient width

// Number of fractional coefficient bits removed after the dot product
`define FAS_COEF_FRAC 15

// Sample times coefficient plus five guard bits for the 32 term sum
`define FAS_ACC_W (`FAS_SAMPLE_W + `FAS_COEF_W + 5)

// Run length counter, wide enough to hold the full tap count
`define FAS_CNT_W 6

`endif

/* fas_pkg.sv */
`include "fas_defs.svh"

package fas_pkg;

  // One input sample or one filter output word
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // Q1.15 filter coefficient
  typedef logic signed [`FAS_COEF_W-1:0] coef_t;

  // Full precision dot product before scaling
  typedef logic signed [`FAS_ACC_W-1:0] acc_t;

  // Low-pass coefficients, entry 0 weights the newest sample
  // The table is symmetric so the phase response stays linear
  // Sum of magnitudes is 30352, so a full-scale input never exceeds sample_t
  localparam coef_t fir_coef [`FAS_TAPS] = '{
    -16'sd40,   -16'sd70,   -16'sd104,  -16'sd132,
    -16'sd140,  -16'sd110,  -16'sd20,    16'sd150,
     16'sd410,   16'sd760,   16'sd1180,  16'sd1640,
     16'sd2100,  16'sd2510,  16'sd2820,  16'sd2990,
     16'sd2990,  16'sd2820,  16'sd2510,  16'sd2100,
     16'sd1640,  16'sd1180,  16'sd760,   16'sd410,
     16'sd150,  -16'sd20,   -16'sd110,  -16'sd140,
    -16'sd132,  -16'sd104,  -16'sd70,   -16'sd40
  };

  // DC gain is about 0.85 with small negative side lobes near the ends

endpackage

/* fas_tb.sv */
`timescale 1ns/1ps
`include "fas_defs.svh"

module fas_tb;

  localparam int clk_period = 10;
  localparam int num_rows = 8;
  localparam int pat_const = 0; // Every sample equals the level column
  localparam int pat_impulse = 1; // Level at run position 32, zero elsewhere
  localparam int pat_alt = 2; // Full-scale positive and negative in turn
  localparam int pat_random = 3;

  // Columns: pattern, run length, gap length, level, expected results, expected frames
  localparam int stim [num_rows][6] = '{
    '{pat_const,   40,  5,   1000,  9, 0}, // Warm-up from reset on a DC input
    '{pat_impulse, 63,  4,  32767, 32, 2}, // Impulse walks through all 32 taps
    '{pat_random,  31,  3,      0,  0, 0}, // One sample short of a full line
    '{pat_random,  70,  6,      0, 39, 2}, // Gap drops a partial frame of 7
    '{pat_alt,     56,  2,      0, 25, 1}, // Worst case swing, 9 words dropped
    '{pat_const,   30,  1, -20000,  0, 0},
    '{pat_random, 100, 10,      0, 69, 4},
    '{pat_random,  47,  8,      0, 16, 1}  // Exactly one frame
  };

  logic             clk;
  logic             rst;
  logic             data_valid;
  fas_pkg::sample_t data;
  logic             fir_valid;
  fas_pkg::sample_t fir_d;
  logic             frame_valid;
  fas_pkg::sample_t frame_d [`FAS_FRAME_LEN];
  logic             check_totals;
  int               exp_fir_total;
  int               exp_frame_total;
  int               errors;
  int               pending;
  int               fir_seen;
  int               frame_seen;

  // Sample for run position pos of table row row, counted from 0
  function automatic fas_pkg::sample_t sample_at(input int row, input int pos);
    case (stim[row][0])
      pat_const:   return fas_pkg::sample_t'(stim[row][3]);
      pat_impulse: return (pos == `FAS_TAPS - 1) ? fas_pkg::sample_t'(stim[row][3]) : '0;
      pat_alt:     return pos[0] ? 16'sh8000 : 16'sh7fff;
      default:     return fas_pkg::sample_t'($urandom);
    endcase
  endfunction

  fas_top fas_top_inst (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

  fas_checker fas_checker_inst (
    .clk             (clk),
    .rst             (rst),
    .data_valid      (data_valid),
    .data            (data),
    .fir_valid       (fir_valid),
    .fir_d           (fir_d),
    .frame_valid     (frame_valid),
    .frame_d         (frame_d),
    .check_totals    (check_totals),
    .exp_fir_total   (exp_fir_total),
    .exp_frame_total (exp_frame_total),
    .errors          (errors),
    .pending         (pending),
    .fir_seen        (fir_seen),
    .frame_seen      (frame_seen)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Limit follows from the table plus reset and drain margin
  initial begin : watchdog
    int limit_cycles;
    limit_cycles = 16 + 100;
    for (int r = 0; r < num_rows; r++) begin
      limit_cycles += stim[r][1] + stim[r][2];
    end
    #(limit_cycles * clk_period);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h9ef5));
    rst = 1'b1;
    data_valid = 1'b0;
    data = '0;
    check_totals = 1'b0;
    exp_fir_total = 0;
    exp_frame_total = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      exp_fir_total += stim[r][4];
      exp_frame_total += stim[r][5];
      for (int n = 0; n < stim[r][1]; n++) begin
        @(posedge clk);
        data_valid <= 1'b1;
        data <= sample_at(r, n);
      end
      for (int g = 0; g < stim[r][2]; g++) begin
        @(posedge clk);
        data_valid <= 1'b0; // Gap breaks the run
        data <= '0;
      end
    end
    @(negedge clk);
    while (pending != 0) @(negedge clk); // Drain what is still in flight
    repeat (4) @(posedge clk); // Room for any stray strobe to show up
    check_totals <= 1'b1;
    @(posedge clk);
    check_totals <= 1'b0;
    @(negedge clk);
    $display("Closing report: %0d errors, %0d filter results and %0d frames seen",
             errors, fir_seen, frame_seen);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* fas_top.sv */
`timescale 1ns/1ps
`include "fas_defs.svh"

module fas_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid, // Sample strobe, no back-pressure
  input  fas_pkg::sample_t data,
  output logic             fir_valid, // Filter result strobe, two cycles after its sample
  output fas_pkg::sample_t fir_d,
  output logic             frame_valid, // Completed frame strobe
  output fas_pkg::sample_t frame_d [`FAS_FRAME_LEN]
);

  fas_pkg::sample_t taps [`FAS_TAPS]; // Tap line contents into the MAC
  logic             taps_valid; // Tap line is full after this shift

  // Sample history with warm-up tracking
  fir_tap_line fir_tap_line_inst (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .taps       (taps),
    .taps_valid (taps_valid)
  );

  // Dot product, scaling and output register
  fir_mac fir_mac_inst (
    .clk        (clk),
    .rst        (rst),
    .taps       (taps),
    .taps_valid (taps_valid),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  // Serial to parallel stage fed by the filter outputs
  frame_collector frame_collector_inst (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame_d     (frame_d)
  );

endmodule

/* fir_mac.sv */
`timescale 1ns/1ps
`include "fas_defs.svh"

module fir_mac (
  input  logic             clk,
  input  logic             rst,
  input  fas_pkg::sample_t taps [`FAS_TAPS], // Tap line contents, newest at index 0
  input  logic             taps_valid, // Tap line is full and has just shifted
  output logic             fir_valid, // One cycle strobe per filter result
  output fas_pkg::sample_t fir_d // Holds the last result between strobes
);

  fas_pkg::acc_t acc; // Full precision dot product
  fas_pkg::acc_t scaled; // Dot product with the Q1.15 fraction removed

  // Dot product over all taps, widened before multiplying so nothing overflows
  always_comb begin
    acc = '0;
    for (int i = 0; i < `FAS_TAPS; i++) begin
      acc = acc + fas_pkg::acc_t'(taps[i]) * fas_pkg::acc_t'(fas_pkg::fir_coef[i]);
    end
  end

  // Arithmetic shift floors toward minus infinity
  assign scaled = acc >>> `FAS_COEF_FRAC;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fir_valid <= 1'b0;
    end else begin
      fir_valid <= taps_valid; // Result follows the tap strobe by one cycle
    end
  end

  // Output word only updates on a new result
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fir_d <= '0;
    end else if (taps_valid) begin
      fir_d <= scaled[`FAS_SAMPLE_W-1:0]; // Coefficient table bounds keep this in range
    end
  end

  // Low bits alone must carry the value, so the upper bits are pure sign extension
  // This ties the tap line contents and the coefficient table to the output width
  a_result_in_range : assert property (
    @(posedge clk) disable iff (rst)
    taps_valid |->
      (fas_pkg::acc_t'(fas_pkg::sample_t'(scaled[`FAS_SAMPLE_W-1:0])) == scaled)
  );

endmodule

/* fir_tap_line.sv */
`timescale 1ns/1ps
`include "fas_defs.svh"

module fir_tap_line (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid, // One accepted sample per high cycle
  input  fas_pkg::sample_t data,
  output fas_pkg::sample_t taps [`FAS_TAPS], // Newest sample sits at index 0
  output logic             taps_valid // Line holds 32 samples of the current run
);

  localparam logic [`FAS_CNT_W-1:0] full_cnt = `FAS_CNT_W'(`FAS_TAPS);

  logic [`FAS_CNT_W-1:0] run_cnt; // Samples accepted in this run up to full_cnt
  logic                  run_full; // Current sample completes or extends a full line

  // The sample being accepted is at least the 32nd when 31 came before it
  assign run_full = (run_cnt >= full_cnt - `FAS_CNT_W'(1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_cnt <= '0;
    end else if (data_valid) begin
      if (run_cnt != full_cnt) begin
        run_cnt <= run_cnt + `FAS_CNT_W'(1); // Stop counting once the line is full
      end
    end else begin
      run_cnt <= '0; // A gap ends the run and warm-up starts over
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      taps_valid <= 1'b0;
    end else begin
      taps_valid <= data_valid && run_full; // Strobe one cycle after acceptance
    end
  end

  // Shift register of the last accepted samples
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `FAS_TAPS; i++) begin
        taps[i] <= '0;
      end
    end else if (data_valid) begin
      taps[0] <= data;
      for (int i = 1; i < `FAS_TAPS; i++) begin
        taps[i] <= taps[i-1]; // Older samples move one slot toward the tail
      end
    end
  end

  // A strobe needs samples accepted both one and 32 cycles earlier
  a_valid_after_sample : assert property (
    @(posedge clk) disable iff (rst)
    taps_valid |-> ($past(data_valid) && $past(data_valid, `FAS_TAPS))
  );

endmodule

/* frame_collector.sv */
`timescale 1ns/1ps
`include "fas_defs.svh"

module frame_collector (
  input  logic             clk,
  input  logic             rst,
  input  logic             fir_valid, // One filter result per high cycle
  input  fas_pkg::sample_t fir_d,
  output logic             frame_valid, // One cycle strobe per completed frame
  output fas_pkg::sample_t frame_d [`FAS_FRAME_LEN] // Word 0 is the oldest result
);

  localparam int idx_w = $clog2(`FAS_FRAME_LEN);
  localparam logic [idx_w-1:0] last_idx = idx_w'(`FAS_FRAME_LEN - 1);

  logic [idx_w-1:0] word_cnt; // Slot that the next result goes into
  logic             frame_done; // The incoming result fills the last slot
  fas_pkg::sample_t word_buf [`FAS_FRAME_LEN-1]; // First words of the frame in progress

  assign frame_done = fir_valid && (word_cnt == last_idx);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      word_cnt    <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= frame_done;
      if (!fir_valid || frame_done) begin
        word_cnt <= '0; // A missing result drops the partial frame
      end else begin
        word_cnt <= word_cnt + idx_w'(1);
      end
    end
  end

  // Collect results until the last slot arrives
  always_ff @(posedge clk) begin
    if (fir_valid && !frame_done) begin
      word_buf[word_cnt] <= fir_d;
    end
  end

  // Publish the buffer together with the final word in one step
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `FAS_FRAME_LEN; i++) begin
        frame_d[i] <= '0;
      end
    end else if (frame_done) begin
      for (int i = 0; i < `FAS_FRAME_LEN - 1; i++) begin
        frame_d[i] <= word_buf[i];
      end
      frame_d[`FAS_FRAME_LEN-1] <= fir_d; // Last word comes straight from the filter
    end
  end

  // Frames take 16 results, so two strobes can never be adjacent
  a_frame_spacing : assert property (
    @(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the FIR and frame collector testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  -f fas.f --top-module fas_tb -Mdir obj_dir -o fas_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/fas_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
